//--- hw/eth_mgmt_pkg.sv
/*
 * Ethernet management block shared definitions.
 * Bus and register widths, CSR map, MDIO timing constants and the
 * request and command structs passed between the blocks.
 */

`default_nettype none

package eth_mgmt_pkg;

  // ========================================
  // bus and register geometry
  // ========================================
  localparam int axi_addr_w = 14;
  localparam int axi_data_w = 64;
  localparam int reg_addr_w = 12;
  localparam int reg_data_w = 32;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  // ========================================
  // register file constants
  // ========================================
  localparam logic [15:0] csr_id_value = 16'h1234;

  // phy reset low pulse, in clock cycles
  localparam int phy_rst_len   = 31;
  localparam int phy_rst_start = 2;

  // ========================================
  // MDIO timing, in MDC half periods
  // ========================================
  // 33 MDC periods per management frame
  localparam int mdio_cnt_max  = 65;
  // preamble after reset, MDIO released
  localparam int mdio_init_max = 125;

  localparam int mdio_default_phy = 1;

  // register word index inside the CSR window
  typedef enum logic [4:0] {
    CSR_CTRL       = 5'd0,
    CSR_SCRATCH    = 5'd1,
    CSR_MDIO_CMD   = 5'd2,
    CSR_MDIO_WDATA = 5'd3,
    CSR_MDIO_RDATA = 5'd4,
    CSR_MDIO_STAT  = 5'd5
  } csr_idx_e;

  typedef enum logic [0:0] {
    MDIO_WRITE = 1'b0,
    MDIO_READ  = 1'b1
  } mdio_op_e;

  // single register access, one cycle wide
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [reg_addr_w-1:0] addr;
    logic [reg_data_w-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    mdio_op_e    op;
    logic [4:0]  phy_addr;
    logic [4:0]  reg_addr;
    logic [15:0] wdata;
  } mdio_cmd_t;

endpackage

`default_nettype wire

//--- hw/axi_reg_slave.sv
/*
 * AXI slave for the management registers.
 * Turns AXI read and write transactions into single-cycle
 * 32-bit register requests and returns OKAY responses.
 */

`default_nettype none

module axi_reg_slave (
  input  wire logic                                s_axi_aclk,
  input  wire logic                                s_axi_aresetn,
  input  wire logic [eth_mgmt_pkg::axi_addr_w-1:0] s_axi_awaddr_i,
  input  wire logic                                s_axi_awvalid_i,
  output      logic                                s_axi_awready_o,
  input  wire logic [eth_mgmt_pkg::axi_data_w-1:0] s_axi_wdata_i,
  input  wire logic                                s_axi_wvalid_i,
  output      logic                                s_axi_wready_o,
  output      logic [1:0]                          s_axi_bresp_o,
  output      logic                                s_axi_bvalid_o,
  input  wire logic                                s_axi_bready_i,
  input  wire logic [eth_mgmt_pkg::axi_addr_w-1:0] s_axi_araddr_i,
  input  wire logic                                s_axi_arvalid_i,
  output      logic                                s_axi_arready_o,
  output      logic [eth_mgmt_pkg::axi_data_w-1:0] s_axi_rdata_o,
  output      logic [1:0]                          s_axi_rresp_o,
  output      logic                                s_axi_rvalid_o,
  input  wire logic                                s_axi_rready_i,
  output      eth_mgmt_pkg::reg_req_t              req_o,
  input  wire logic [eth_mgmt_pkg::reg_data_w-1:0] rdata_i
);

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_DATA, RD_RESP} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_e;

  rd_state_e rd_state;
  wr_state_e wr_state;

  logic [eth_mgmt_pkg::reg_addr_w-1:0] raddr_q;
  logic [eth_mgmt_pkg::reg_addr_w-1:0] waddr_q;
  logic [eth_mgmt_pkg::axi_data_w-1:0] wdata_q;
  logic [eth_mgmt_pkg::reg_data_w-1:0] rdata_q;

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic wr_go;
  logic rd_go;

  assign ar_hs = s_axi_arvalid_i & s_axi_arready_o;
  assign aw_hs = s_axi_awvalid_i & s_axi_awready_o;
  assign w_hs  = s_axi_wvalid_i & s_axi_wready_o;

  // a write request wins, a colliding read waits one cycle
  assign wr_go = (wr_state == WR_REQ);
  assign rd_go = (rd_state == RD_REQ) & ~wr_go;

  always_comb begin
    req_o.wr    = wr_go;
    req_o.rd    = rd_go;
    req_o.addr  = wr_go ? waddr_q : raddr_q;
    // word index bit 0 picks the 32-bit lane
    req_o.wdata = waddr_q[0] ? wdata_q[eth_mgmt_pkg::axi_data_w-1:eth_mgmt_pkg::reg_data_w]
                             : wdata_q[eth_mgmt_pkg::reg_data_w-1:0];
  end

  assign s_axi_rdata_o = {2{rdata_q}};
  assign s_axi_rresp_o = eth_mgmt_pkg::axi_resp_okay;
  assign s_axi_bresp_o = eth_mgmt_pkg::axi_resp_okay;

  // address and data capture
  always_ff @(posedge s_axi_aclk) begin
    if (ar_hs) begin
      raddr_q <= s_axi_araddr_i[eth_mgmt_pkg::axi_addr_w-1:2];
    end
    if (aw_hs) begin
      waddr_q <= s_axi_awaddr_i[eth_mgmt_pkg::axi_addr_w-1:2];
    end
    if (w_hs) begin
      wdata_q <= s_axi_wdata_i;
    end
    if (rd_go) begin
      rdata_q <= rdata_i;
    end
  end

  // ========================================
  // read channel
  // ========================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state        <= RD_IDLE;
      s_axi_arready_o <= 1'b1;
      s_axi_rvalid_o  <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (ar_hs) begin
            s_axi_arready_o <= 1'b0;
            rd_state        <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (rd_go) begin
            rd_state <= RD_DATA;
          end
        end
        RD_DATA: begin
          s_axi_rvalid_o <= 1'b1;
          rd_state       <= RD_RESP;
        end
        RD_RESP: begin
          if (s_axi_rready_i) begin
            s_axi_rvalid_o  <= 1'b0;
            s_axi_arready_o <= 1'b1;
            rd_state        <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // ========================================
  // write channel
  // ========================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state        <= WR_IDLE;
      s_axi_awready_o <= 1'b1;
      s_axi_wready_o  <= 1'b1;
      s_axi_bvalid_o  <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (aw_hs) begin
            s_axi_awready_o <= 1'b0;
          end
          if (w_hs) begin
            s_axi_wready_o <= 1'b0;
          end
          // both beats in, possibly in the same cycle
          if ((aw_hs | ~s_axi_awready_o) && (w_hs | ~s_axi_wready_o)) begin
            wr_state <= WR_REQ;
          end
        end
        WR_REQ: begin
          s_axi_bvalid_o <= 1'b1;
          wr_state       <= WR_RESP;
        end
        WR_RESP: begin
          if (s_axi_bready_i) begin
            s_axi_bvalid_o  <= 1'b0;
            s_axi_awready_o <= 1'b1;
            s_axi_wready_o  <= 1'b1;
            wr_state        <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/mac_csr.sv
/*
 * Management control and status registers.
 * Holds scratch and MDIO command registers, drives the read mux
 * and generates the self-timed PHY reset pulse.
 */

`default_nettype none

module mac_csr (
  input  wire logic                                s_axi_aclk,
  input  wire logic                                s_axi_aresetn,
  input  wire eth_mgmt_pkg::reg_req_t              req_i,
  output      logic [eth_mgmt_pkg::reg_data_w-1:0] rdata_o,
  output      eth_mgmt_pkg::mdio_cmd_t             mdio_cmd_o,
  output      logic                                mdio_start_o,
  output      logic                                mdio_init_kick_o,
  input  wire logic                                mdio_busy_i,
  input  wire logic                                mdio_init_i,
  input  wire logic [15:0]                         mdio_rdata_i,
  output      logic                                phy_rst_n_o
);

  eth_mgmt_pkg::csr_idx_e idx;

  logic        win_sel;
  logic        wr_ctrl;
  logic        wr_stat;
  logic [31:0] scratch_q;
  logic [5:0]  phy_rst_cnt;

  // register window is the first 32 words
  assign win_sel = (req_i.addr[eth_mgmt_pkg::reg_addr_w-1:5] == '0);
  assign idx     = eth_mgmt_pkg::csr_idx_e'(req_i.addr[4:0]);

  assign wr_ctrl = req_i.wr & win_sel & (idx == eth_mgmt_pkg::CSR_CTRL);
  assign wr_stat = req_i.wr & win_sel & (idx == eth_mgmt_pkg::CSR_MDIO_STAT);

  assign mdio_start_o     = wr_stat & req_i.wdata[0];
  assign mdio_init_kick_o = wr_stat & req_i.wdata[4];

  // ========================================
  // writable registers
  // ========================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      scratch_q           <= '0;
      mdio_cmd_o.op       <= eth_mgmt_pkg::MDIO_WRITE;
      mdio_cmd_o.phy_addr <= 5'(eth_mgmt_pkg::mdio_default_phy);
      mdio_cmd_o.reg_addr <= 5'd0;
      mdio_cmd_o.wdata    <= 16'h0;
    end else if (req_i.wr && win_sel) begin
      case (idx)
        eth_mgmt_pkg::CSR_SCRATCH: begin
          scratch_q <= req_i.wdata;
        end
        eth_mgmt_pkg::CSR_MDIO_CMD: begin
          mdio_cmd_o.op       <= eth_mgmt_pkg::mdio_op_e'(req_i.wdata[10]);
          mdio_cmd_o.phy_addr <= req_i.wdata[9:5];
          mdio_cmd_o.reg_addr <= req_i.wdata[4:0];
        end
        eth_mgmt_pkg::CSR_MDIO_WDATA: begin
          mdio_cmd_o.wdata <= req_i.wdata[15:0];
        end
        default: begin
        end
      endcase
    end
  end

  // ========================================
  // phy reset pulse
  // ========================================
  // count runs 1..32, output low on counts 2..32
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      phy_rst_cnt <= 6'd0;
    end else if (wr_ctrl && req_i.wdata[0]) begin
      phy_rst_cnt <= 6'd1;
    end else if (phy_rst_cnt >= eth_mgmt_pkg::phy_rst_start + eth_mgmt_pkg::phy_rst_len - 1) begin
      phy_rst_cnt <= 6'd0;
    end else if (phy_rst_cnt != 6'd0) begin
      phy_rst_cnt <= phy_rst_cnt + 6'd1;
    end
  end

  assign phy_rst_n_o = ~((phy_rst_cnt >= eth_mgmt_pkg::phy_rst_start) &&
                         (phy_rst_cnt <= eth_mgmt_pkg::phy_rst_start +
                                         eth_mgmt_pkg::phy_rst_len - 1));

  // read mux, valid in the request cycle
  always_comb begin
    rdata_o = '0;
    if (win_sel) begin
      case (idx)
        eth_mgmt_pkg::CSR_CTRL:       rdata_o = {eth_mgmt_pkg::csr_id_value, 16'h0};
        eth_mgmt_pkg::CSR_SCRATCH:    rdata_o = scratch_q;
        eth_mgmt_pkg::CSR_MDIO_CMD: begin
          rdata_o = {21'h0, mdio_cmd_o.op, mdio_cmd_o.phy_addr, mdio_cmd_o.reg_addr};
        end
        eth_mgmt_pkg::CSR_MDIO_WDATA: rdata_o = {16'h0, mdio_cmd_o.wdata};
        eth_mgmt_pkg::CSR_MDIO_RDATA: rdata_o = {16'h0, mdio_rdata_i};
        eth_mgmt_pkg::CSR_MDIO_STAT:  rdata_o = {27'h0, mdio_init_i, 3'h0, mdio_busy_i};
        default:                      rdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/mdio_master.sv
/*
 * MDIO management master.
 * Generates MDC, runs the post-reset preamble and shifts
 * read and write management frames on MDIO.
 */

`default_nettype none

module mdio_master (
  input  wire logic                    s_axi_aclk,
  input  wire logic                    s_axi_aresetn,
  input  wire eth_mgmt_pkg::mdio_cmd_t cmd_i,
  input  wire logic                    start_i,
  input  wire logic                    init_kick_i,
  output      logic                    busy_o,
  output      logic                    init_active_o,
  output      logic [15:0]             rdata_o,
  input  wire logic                    phy_mdio_i,
  output      logic                    phy_mdio_o,
  output      logic                    phy_mdio_t_o,
  output      logic                    phy_mdc_o
);

  logic [6:0]  cnt;
  logic [5:0]  bit_idx;
  logic        init_run;
  logic        is_read;
  logic [31:0] frame;

  // MDC period number within the frame
  assign bit_idx = cnt[6:1];
  assign is_read = (cmd_i.op == eth_mgmt_pkg::MDIO_READ);

  // start, op, phy, reg, turnaround, data
  assign frame = {2'b01, cmd_i.op, ~cmd_i.op, cmd_i.phy_addr, cmd_i.reg_addr, 2'b10,
                  is_read ? 16'h0 : cmd_i.wdata};

  assign phy_mdc_o = cnt[0];

  // released during init and from turnaround onward on reads
  assign phy_mdio_t_o = init_active_o | (busy_o & is_read & (cnt > 7'd29));

  // ========================================
  // half-period counter
  // ========================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      cnt           <= 7'd0;
      busy_o        <= 1'b0;
      init_run      <= 1'b0;
      init_active_o <= 1'b1;
    end else if (init_run) begin
      if (cnt >= eth_mgmt_pkg::mdio_init_max) begin
        cnt           <= 7'd0;
        init_run      <= 1'b0;
        init_active_o <= 1'b0;
      end else begin
        cnt <= cnt + 7'd1;
      end
    end else if (busy_o) begin
      if (cnt >= eth_mgmt_pkg::mdio_cnt_max) begin
        cnt    <= 7'd0;
        busy_o <= 1'b0;
      end else begin
        cnt <= cnt + 7'd1;
      end
    end else if (init_kick_i && init_active_o) begin
      // preamble starts with MDC high
      cnt      <= 7'd1;
      init_run <= 1'b1;
    end else if (start_i) begin
      busy_o <= 1'b1;
    end
  end

  // ========================================
  // frame shift and read capture
  // ========================================
  // MDIO changes and is sampled as MDC falls
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      phy_mdio_o <= 1'b1;
      rdata_o    <= 16'h0;
    end else begin
      if (busy_o && cnt[0]) begin
        if (bit_idx < 6'd32) begin
          phy_mdio_o <= frame[~bit_idx[4:0]];
        end else begin
          phy_mdio_o <= 1'b1;
        end
      end
      if (busy_o && is_read && cnt[0] && (bit_idx > 6'd15) && (bit_idx < 6'd32)) begin
        rdata_o <= {rdata_o[14:0], phy_mdio_i};
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/eth_mgmt_top.sv
/*
 * Ethernet MAC-lite management block.
 * AXI register slave, CSR file and MDIO master.
 */

`default_nettype none

module eth_mgmt_top (
  input  wire logic                                s_axi_aclk,
  input  wire logic                                s_axi_aresetn,
  input  wire logic [eth_mgmt_pkg::axi_addr_w-1:0] s_axi_awaddr_i,
  input  wire logic                                s_axi_awvalid_i,
  output      logic                                s_axi_awready_o,
  input  wire logic [eth_mgmt_pkg::axi_data_w-1:0] s_axi_wdata_i,
  // full-word registers only, strobes ignored
  input  wire logic [7:0]                          s_axi_wstrb_i,
  input  wire logic                                s_axi_wvalid_i,
  output      logic                                s_axi_wready_o,
  output      logic [1:0]                          s_axi_bresp_o,
  output      logic                                s_axi_bvalid_o,
  input  wire logic                                s_axi_bready_i,
  input  wire logic [eth_mgmt_pkg::axi_addr_w-1:0] s_axi_araddr_i,
  input  wire logic                                s_axi_arvalid_i,
  output      logic                                s_axi_arready_o,
  output      logic [eth_mgmt_pkg::axi_data_w-1:0] s_axi_rdata_o,
  output      logic [1:0]                          s_axi_rresp_o,
  output      logic                                s_axi_rvalid_o,
  input  wire logic                                s_axi_rready_i,
  input  wire logic                                phy_mdio_i,
  output      logic                                phy_mdio_o,
  output      logic                                phy_mdio_t_o,
  output      logic                                phy_mdc_o,
  output      logic                                phy_rst_n_o
);

  eth_mgmt_pkg::reg_req_t              req;
  eth_mgmt_pkg::mdio_cmd_t             mdio_cmd;
  logic [eth_mgmt_pkg::reg_data_w-1:0] reg_rdata;
  logic                                mdio_start;
  logic                                mdio_init_kick;
  logic                                mdio_busy;
  logic                                mdio_init;
  logic [15:0]                         mdio_rdata;

  axi_reg_slave u_axi_reg_slave (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .req_o           (req),
    .rdata_i         (reg_rdata)
  );

  mac_csr u_mac_csr (
    .s_axi_aclk       (s_axi_aclk),
    .s_axi_aresetn    (s_axi_aresetn),
    .req_i            (req),
    .rdata_o          (reg_rdata),
    .mdio_cmd_o       (mdio_cmd),
    .mdio_start_o     (mdio_start),
    .mdio_init_kick_o (mdio_init_kick),
    .mdio_busy_i      (mdio_busy),
    .mdio_init_i      (mdio_init),
    .mdio_rdata_i     (mdio_rdata),
    .phy_rst_n_o      (phy_rst_n_o)
  );

  mdio_master u_mdio_master (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .cmd_i         (mdio_cmd),
    .start_i       (mdio_start),
    .init_kick_i   (mdio_init_kick),
    .busy_o        (mdio_busy),
    .init_active_o (mdio_init),
    .rdata_o       (mdio_rdata),
    .phy_mdio_i    (phy_mdio_i),
    .phy_mdio_o    (phy_mdio_o),
    .phy_mdio_t_o  (phy_mdio_t_o),
    .phy_mdc_o     (phy_mdc_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_eth_mgmt.sv
/*
 * Testbench for the Ethernet management block.
 * Runs the data-file steps through the AXI slave against a small PHY model.
 */

`default_nettype none

module tb_eth_mgmt;

  localparam int wait_limit = 200;
  localparam int poll_limit = 40;

  logic        s_axi_aclk;
  logic        s_axi_aresetn;
  logic [13:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [63:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [13:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [63:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        phy_mdio_i;
  logic        phy_mdio_o;
  logic        phy_mdio_t;
  logic        phy_mdc;
  logic        phy_rst_n;

  integer      seed;
  integer      rise_cnt;
  integer      low_run;
  integer      last_pulse;
  logic        tri_ok;
  logic [15:0] phy_val;
  logic [31:0] cap;

  eth_mgmt_top dut (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (8'hff),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .phy_mdio_i      (phy_mdio_i),
    .phy_mdio_o      (phy_mdio_o),
    .phy_mdio_t_o    (phy_mdio_t),
    .phy_mdc_o       (phy_mdc),
    .phy_rst_n_o     (phy_rst_n)
  );

  always #10 s_axi_aclk = ~s_axi_aclk;

  task automatic check(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // word index bit 0 selects the upper lane
  function automatic logic [63:0] lane_beat(input logic [13:0] addr, input logic [31:0] val);
    return addr[2] ? {val, 32'h0} : {32'h0, val};
  endfunction

  // ========================================
  // AXI driver
  // ========================================
  task automatic axi_write(input logic [13:0] addr, input logic [63:0] data,
                           output logic [1:0] resp);
    integer w_delay;
    integer b_delay;
    integer cyc;
    logic   aw_ok;
    logic   w_ok;
    logic   aw_hit;
    logic   w_hit;
    w_delay = $unsigned($random(seed)) % 3;
    b_delay = $unsigned($random(seed)) % 4;
    cyc = 0;
    aw_ok = 1'b0;
    w_ok = 1'b0;
    @(posedge s_axi_aclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    if (w_delay == 0) begin
      wvalid <= 1'b1;
    end
    while (!(aw_ok && w_ok)) begin
      @(negedge s_axi_aclk);
      cyc = cyc + 1;
      if (cyc > wait_limit) begin
        timeout("AW/W handshake");
      end
      aw_hit = awvalid & awready;
      w_hit  = wvalid & wready;
      @(posedge s_axi_aclk);
      if (aw_hit) begin
        awvalid <= 1'b0;
        aw_ok = 1'b1;
      end
      if (w_hit) begin
        wvalid <= 1'b0;
        w_ok = 1'b1;
      end else if (!w_ok && !wvalid && cyc >= w_delay) begin
        wvalid <= 1'b1;
      end
    end
    // hold off bready to stall the slave
    repeat (b_delay) @(posedge s_axi_aclk);
    bready <= 1'b1;
    cyc = 0;
    do begin
      @(negedge s_axi_aclk);
      cyc = cyc + 1;
      if (cyc > wait_limit) begin
        timeout("write response");
      end
    end while (!(bvalid && bready));
    resp = bresp;
    @(posedge s_axi_aclk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [13:0] addr, output logic [63:0] data,
                          output logic [1:0] resp);
    integer r_delay;
    integer cyc;
    r_delay = $unsigned($random(seed)) % 4;
    cyc = 0;
    @(posedge s_axi_aclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do begin
      @(negedge s_axi_aclk);
      cyc = cyc + 1;
      if (cyc > wait_limit) begin
        timeout("AR handshake");
      end
    end while (!(arvalid && arready));
    @(posedge s_axi_aclk);
    arvalid <= 1'b0;
    repeat (r_delay) @(posedge s_axi_aclk);
    rready <= 1'b1;
    cyc = 0;
    do begin
      @(negedge s_axi_aclk);
      cyc = cyc + 1;
      if (cyc > wait_limit) begin
        timeout("read data");
      end
    end while (!(rvalid && rready));
    data = rdata;
    resp = rresp;
    @(posedge s_axi_aclk);
    rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] val);
    logic [1:0] resp;
    axi_write(addr, lane_beat(addr, val), resp);
    check("bresp", 2'b00, resp);
  endtask

  task automatic read_reg(input logic [13:0] addr, output logic [31:0] val);
    logic [63:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check("rresp", 2'b00, resp);
    check("rdata halves", data[63:32], data[31:0]);
    val = data[31:0];
  endtask

  task automatic run_mdio(input logic [10:0] cmd, input logic [15:0] val,
                          input logic [15:0] exp_v);
    logic [31:0] stat;
    logic [31:0] frame;
    integer      n;
    // PHY answers a read with the expected value
    phy_val = exp_v;
    rise_cnt = 0;
    tri_ok = 1'b1;
    write_reg(14'h0008, {21'h0, cmd});
    write_reg(14'h000c, {16'h0, val});
    write_reg(14'h0014, 32'h1);
    n = 0;
    stat = 32'h1;
    while (stat[0]) begin
      n = n + 1;
      if (n > poll_limit) begin
        timeout("MDIO busy to clear");
      end
      read_reg(14'h0014, stat);
    end
    if (cmd[10]) begin
      read_reg(14'h0010, stat);
      check("MDIO_RDATA", exp_v, stat);
      check("phy_mdio_t during data", 1'b1, tri_ok);
    end else begin
      frame = {2'b01, cmd[10], ~cmd[10], cmd[9:5], cmd[4:0], 2'b10, val};
      check("mdio frame", frame, cap);
    end
  endtask

  // ========================================
  // PHY model and monitors
  // ========================================
  // the last 32 rising MDC samples hold the frame
  always @(posedge phy_mdc) begin
    cap <= {cap[30:0], phy_mdio_o};
    if (rise_cnt >= 16 && rise_cnt <= 31) begin
      phy_mdio_i <= phy_val[31 - rise_cnt];
      if (!phy_mdio_t) begin
        tri_ok = 1'b0;
      end
    end else begin
      phy_mdio_i <= 1'b1;
    end
    rise_cnt = rise_cnt + 1;
  end

  always @(negedge s_axi_aclk) begin
    if (!phy_rst_n) begin
      low_run = low_run + 1;
    end else if (low_run != 0) begin
      last_pulse = low_run;
      low_run = 0;
    end
  end

  initial begin
    integer      fd;
    integer      r;
    integer      n;
    logic [7:0]  op;
    logic [13:0] addr;
    logic [63:0] data;
    logic [31:0] exp_v;
    logic [31:0] val;
    logic [1:0]  resp;
    logic [8*256-1:0] line;
    seed = 30532;
    rise_cnt = 0;
    low_run = 0;
    last_pulse = 0;
    tri_ok = 1'b1;
    phy_val = 16'h0;
    cap = 32'h0;
    s_axi_aclk = 1'b0;
    s_axi_aresetn = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    phy_mdio_i = 1'b1;
    repeat (4) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    fd = $fopen("tb/eth_mgmt_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      $display("=== FAIL ===");
      $fatal(1);
    end
    r = $fscanf(fd, " %s", op);
    while (r == 1) begin
      if (op == "#") begin
        r = $fgets(line, fd);
      end else begin
        r = $fscanf(fd, " %h %h %h", addr, data, exp_v);
        case (op)
          "W": begin
            // register value may sit in either lane of the data column
            val = data[63:32] | data[31:0];
            axi_write(addr, lane_beat(addr, val), resp);
            check("bresp", exp_v, resp);
          end
          "R": begin
            n = 0;
            read_reg(addr, val);
            // nonzero data field polls until the value matches
            while (data != 0 && val != exp_v) begin
              n = n + 1;
              if (n > data) begin
                timeout("register to reach its expected value");
              end
              read_reg(addr, val);
            end
            check("rdata", exp_v, val);
          end
          "M": run_mdio(addr[10:0], data[15:0], exp_v[15:0]);
          "P": begin
            last_pulse = 0;
            write_reg(addr, data[31:0]);
            n = 0;
            while (last_pulse == 0) begin
              n = n + 1;
              if (n > wait_limit) begin
                timeout("phy reset pulse to end");
              end
              @(negedge s_axi_aclk);
            end
            check("phy_rst_n_o low cycles", exp_v, last_pulse);
          end
          default: begin
            $display("unknown op code in the test data file");
            $display("=== FAIL ===");
            $fatal(1);
          end
        endcase
      end
      r = $fscanf(fd, " %s", op);
    end
    $fclose(fd);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/eth_mgmt_testdata.txt
# op addr data expect, all hex; W write, R read (data = poll limit), P phy reset
# M mdio: addr = command bits 10:0, data = write data or PHY read value
R 0014 0 00000010
W 0014 0000000000000010 0
R 0014 40 00000000
R 0000 0 12340000
W 0004 DEADBEEF00000000 0
R 0004 0 DEADBEEF
W 0008 00000000000004A3 0
R 0008 0 000004A3
W 000C 000055AA00000000 0
R 000C 0 000055AA
R 0018 0 00000000
R 0100 0 00000000
P 0000 1 1F
M 0123 BEEF 0
M 0422 A5C3 A5C3
R 0010 0 0000A5C3
M 07FF 0F0F 0

//--- all.f
hw/eth_mgmt_pkg.sv
hw/axi_reg_slave.sv
hw/mac_csr.sv
hw/mdio_master.sv
hw/eth_mgmt_top.sv
tb/tb_eth_mgmt.sv

//--- Bender.yml
package:
  name: eth_mgmt

sources:
  - files:
      - hw/eth_mgmt_pkg.sv
      - hw/axi_reg_slave.sv
      - hw/mac_csr.sv
      - hw/mdio_master.sv
      - hw/eth_mgmt_top.sv
  - target: test
    files:
      - tb/tb_eth_mgmt.sv
